// ==== design/ord_rd_pkg.sv ====
// Shared widths, depths and latencies of the ordered read subsystem.
// Every design file imports this package; nothing here holds state.
`default_nettype none

package ord_rd_pkg;

    // Memory word address and word width
    localparam int ADDR_BITS = 8;
    localparam int DATA_BITS = 32;

    // Scoreboard geometry, metadata is the client number
    localparam int N_ENTRIES = 16;
    localparam int IDX_BITS = $clog2(N_ENTRIES);
    localparam int META_BITS = 1;
    localparam int MIN_FREE_SLOTS = 1;

    // Output FIFO is almost full with FIFO_THRESHOLD or fewer free slots
    localparam int FIFO_ENTRIES = 4;
    localparam int FIFO_THRESHOLD = 2;

    // Cycles from request acceptance to response, per bank
    localparam int EVEN_LATENCY = 2;
    localparam int ODD_LATENCY = 5;

    // Memory contents are address times this odd constant, kept to 32 bits
    localparam logic [31:0] ROM_MULT = 32'h9e37_79b1;

endpackage

`default_nettype wire

// ==== design/ord_rd_ifs.sv ====
// Interfaces between the arbiter, the memory and the scoreboard.
// rd_req_if is the memory request channel, sb_alloc_if the entry allocation port.
`timescale 1ns/100ps
`default_nettype none

interface rd_req_if;
    import ord_rd_pkg::*;

    // A transfer happens when valid and ready are both high
    logic                 valid;
    logic                 ready;
    logic [ADDR_BITS-1:0] addr;
    // Scoreboard entry that receives the response data
    logic [IDX_BITS-1:0]  idx;

    modport source (output valid, output addr, output idx, input ready);
    modport sink (input valid, input addr, input idx, output ready);

endinterface

interface sb_alloc_if;
    import ord_rd_pkg::*;

    // Raised only in the cycle the memory request transfers
    logic                 enq_en;
    logic [META_BITS-1:0] meta;
    // enq_idx names the next free entry whenever not_full is high
    logic                 not_full;
    logic [IDX_BITS-1:0]  enq_idx;

    modport requester (output enq_en, output meta, input not_full, input enq_idx);
    modport provider (input enq_en, input meta, output not_full, output enq_idx);

endinterface

`default_nettype wire

// ==== design/rd_scoreboard.sv ====
// Reorder scoreboard. Entries are allocated in grant order, filled by index
// as responses arrive in any order, and released from the head in order.
// The head is offered one cycle after its data is written.
`timescale 1ns/100ps
`default_nettype none

module rd_scoreboard
(
    input  wire logic                            clk,
    input  wire logic                            reset,
    sb_alloc_if.provider                         alloc,
    input  wire logic                            rsp_valid,
    input  wire logic [ord_rd_pkg::IDX_BITS-1:0]  rsp_idx,
    input  wire logic [ord_rd_pkg::DATA_BITS-1:0] rsp_data,
    input  wire logic                            deq_en,
    output logic                                 not_empty,
    output logic [ord_rd_pkg::DATA_BITS-1:0]      first,
    output logic [ord_rd_pkg::META_BITS-1:0]      first_meta
);
    import ord_rd_pkg::*;

    // Entry storage, written without reset like a LUT RAM
    logic [META_BITS-1:0] meta_mem [N_ENTRIES];
    logic [DATA_BITS-1:0] data_mem [N_ENTRIES];

    // One bit per entry, set when its response data has been written
    logic [N_ENTRIES-1:0] data_valid;
    logic [IDX_BITS-1:0]  tail_idx;
    logic [IDX_BITS-1:0]  head_idx;
    logic [IDX_BITS:0]    free_cnt;
    logic [IDX_BITS:0]    used_cnt;
    logic [IDX_BITS-1:0]  rsp_offset;

    assign alloc.enq_idx = tail_idx;
    // Full once fewer than MIN_FREE_SLOTS entries remain free
    assign alloc.not_full = (free_cnt >= (IDX_BITS+1)'(MIN_FREE_SLOTS));

    // The head is ready only when its data has landed
    assign not_empty = data_valid[head_idx];
    assign first = data_mem[head_idx];
    assign first_meta = meta_mem[head_idx];

    always_ff @(posedge clk)
    begin
        if (alloc.enq_en)
            meta_mem[tail_idx] <= alloc.meta;
        if (rsp_valid)
            data_mem[rsp_idx] <= rsp_data;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            tail_idx <= '0;
            head_idx <= '0;
            free_cnt <= (IDX_BITS+1)'(N_ENTRIES);
            data_valid <= '0;
        end
        else
        begin
            if (alloc.enq_en)
                tail_idx <= tail_idx + 1'b1;
            // A dequeued entry and a written entry can never be the same one
            if (deq_en)
            begin
                head_idx <= head_idx + 1'b1;
                data_valid[head_idx] <= 1'b0;
            end
            if (rsp_valid)
                data_valid[rsp_idx] <= 1'b1;
            free_cnt <= free_cnt + {{IDX_BITS{1'b0}}, deq_en}
                                 - {{IDX_BITS{1'b0}}, alloc.enq_en};
        end
    end

    // Distance of a response index from the head, used to check allocation
    assign used_cnt = (IDX_BITS+1)'(N_ENTRIES) - free_cnt;
    assign rsp_offset = rsp_idx - head_idx;

    // A response must land in a live entry that still waits for its data
    a_rsp_allocated: assert property (@(posedge clk) disable iff (reset)
        rsp_valid |-> ({1'b0, rsp_offset} < used_cnt) && !data_valid[rsp_idx]);

    // The output buffer only pulls the head when it is offered
    a_deq_not_empty: assert property (@(posedge clk) disable iff (reset)
        deq_en |-> not_empty);

endmodule

`default_nettype wire

// ==== design/lutram_fifo.sv ====
// Small register-file FIFO carrying one data word plus its metadata.
// almost_full gives the writer early warning so words already in flight fit.
`timescale 1ns/100ps
`default_nettype none

module lutram_fifo
(
    input  wire logic                                                clk,
    input  wire logic                                                reset,
    input  wire logic                                                enq_en,
    input  wire logic [ord_rd_pkg::DATA_BITS+ord_rd_pkg::META_BITS-1:0] enq_data,
    output logic                                                     almost_full,
    input  wire logic                                                deq_en,
    output logic                                                     not_empty,
    output logic [ord_rd_pkg::DATA_BITS+ord_rd_pkg::META_BITS-1:0]      first
);
    import ord_rd_pkg::*;

    localparam int PTR_BITS = $clog2(FIFO_ENTRIES);

    logic [DATA_BITS+META_BITS-1:0] mem [FIFO_ENTRIES];
    logic [PTR_BITS-1:0]            wr_ptr;
    logic [PTR_BITS-1:0]            rd_ptr;
    logic [PTR_BITS:0]              count;
    logic [PTR_BITS:0]              free_slots;

    assign free_slots = (PTR_BITS+1)'(FIFO_ENTRIES) - count;
    assign almost_full = (free_slots <= (PTR_BITS+1)'(FIFO_THRESHOLD));
    assign not_empty = (count != '0);
    assign first = mem[rd_ptr];

    always_ff @(posedge clk)
    begin
        if (enq_en)
            mem[wr_ptr] <= enq_data;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end
        else
        begin
            if (enq_en)
                wr_ptr <= wr_ptr + 1'b1;
            if (deq_en)
                rd_ptr <= rd_ptr + 1'b1;
            count <= count + {{PTR_BITS{1'b0}}, enq_en} - {{PTR_BITS{1'b0}}, deq_en};
        end
    end

    // The writer's threshold must leave room for everything it has in flight
    a_no_overflow: assert property (@(posedge clk) disable iff (reset)
        enq_en |-> (count < (PTR_BITS+1)'(FIFO_ENTRIES)));

endmodule

`default_nettype wire

// ==== design/rd_scoreboard_obuf.sv ====
// Scoreboard with a registered output and a small FIFO behind it.
// The register stage cuts the path from the output ready back into the
// scoreboard, while the FIFO keeps one word per cycle flowing.
`timescale 1ns/100ps
`default_nettype none

module rd_scoreboard_obuf
(
    input  wire logic                            clk,
    input  wire logic                            reset,
    sb_alloc_if.provider                         alloc,
    input  wire logic                            rsp_valid,
    input  wire logic [ord_rd_pkg::IDX_BITS-1:0]  rsp_idx,
    input  wire logic [ord_rd_pkg::DATA_BITS-1:0] rsp_data,
    input  wire logic                            deq_en,
    output logic                                 not_empty,
    output logic [ord_rd_pkg::DATA_BITS-1:0]      first,
    output logic [ord_rd_pkg::META_BITS-1:0]      first_meta
);
    import ord_rd_pkg::*;

    logic                           sb_deq_en;
    logic                           sb_not_empty;
    logic [DATA_BITS-1:0]           sb_first;
    logic [META_BITS-1:0]           sb_first_meta;
    logic                           fifo_almost_full;
    logic [DATA_BITS+META_BITS-1:0] fifo_first;

    rd_scoreboard sb_i
    (
        .clk        (clk),
        .reset      (reset),
        .alloc      (alloc),
        .rsp_valid  (rsp_valid),
        .rsp_idx    (rsp_idx),
        .rsp_data   (rsp_data),
        .deq_en     (sb_deq_en),
        .not_empty  (sb_not_empty),
        .first      (sb_first),
        .first_meta (sb_first_meta)
    );

    // Pull the head whenever the FIFO can also absorb the word in flight
    assign sb_deq_en = sb_not_empty && !fifo_almost_full;

    // One register cycle between the scoreboard read and the FIFO write
    logic                           sb_deq_en_q;
    logic [DATA_BITS+META_BITS-1:0] sb_word_q;

    always_ff @(posedge clk)
    begin
        if (reset)
            sb_deq_en_q <= 1'b0;
        else
            sb_deq_en_q <= sb_deq_en;
        sb_word_q <= {sb_first_meta, sb_first};
    end

    lutram_fifo fifo_i
    (
        .clk         (clk),
        .reset       (reset),
        .enq_en      (sb_deq_en_q),
        .enq_data    (sb_word_q),
        .almost_full (fifo_almost_full),
        .deq_en      (deq_en),
        .not_empty   (not_empty),
        .first       (fifo_first)
    );

    // Metadata sits above the data in the FIFO word
    assign first = fifo_first[DATA_BITS-1:0];
    assign first_meta = fifo_first[DATA_BITS+META_BITS-1:DATA_BITS];

endmodule

`default_nettype wire

// ==== design/req_arbiter.sv ====
// Round-robin arbiter of two read clients onto the memory request channel.
// A grant also allocates a scoreboard entry, whose index rides with the request.
// Grant is combinational; only the priority pointer and a hold flag are state.
`timescale 1ns/100ps
`default_nettype none

module req_arbiter
(
    input  wire logic                            clk,
    input  wire logic                            reset,
    input  wire logic                            req0_valid,
    output logic                                 req0_ready,
    input  wire logic [ord_rd_pkg::ADDR_BITS-1:0] req0_addr,
    input  wire logic                            req1_valid,
    output logic                                 req1_ready,
    input  wire logic [ord_rd_pkg::ADDR_BITS-1:0] req1_addr,
    rd_req_if.source                             mem,
    sb_alloc_if.requester                        alloc
);
    import ord_rd_pkg::*;

    // Client that wins a tie
    logic rr_ptr;
    // Set while an offered request waits for the memory, so the choice holds
    logic lock_q;
    logic lock_client_q;
    logic sel;
    logic xfer;

    always_comb
    begin
        if (lock_q)
            sel = lock_client_q;
        else if (req0_valid && req1_valid)
            sel = rr_ptr;
        else
            sel = req1_valid;
    end

    // Only offer a request when an entry can be allocated for it
    assign mem.valid = (req0_valid || req1_valid) && alloc.not_full;
    assign mem.addr = sel ? req1_addr : req0_addr;
    assign mem.idx = alloc.enq_idx;
    assign xfer = mem.valid && mem.ready;

    assign alloc.enq_en = xfer;
    assign alloc.meta = META_BITS'(sel);

    assign req0_ready = xfer && !sel;
    assign req1_ready = xfer && sel;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rr_ptr <= 1'b0;
            lock_q <= 1'b0;
            lock_client_q <= 1'b0;
        end
        else
        begin
            // The other client gets priority after each transfer
            if (xfer)
                rr_ptr <= !sel;
            lock_q <= mem.valid && !mem.ready;
            lock_client_q <= sel;
        end
    end

    // At most one client is ready, and only a client that is requesting
    a_one_ready: assert property (@(posedge clk) disable iff (reset)
        !(req0_ready && req1_ready) && (!req0_ready || req0_valid)
            && (!req1_ready || req1_valid));

    // A request turned away by the memory comes back unchanged next cycle
    a_req_stable: assert property (@(posedge clk) disable iff (reset)
        mem.valid && !mem.ready |=> mem.valid && $stable(mem.addr) && $stable(mem.idx));

endmodule

`default_nettype wire

// ==== design/bank_memory.sv ====
// Read-only two-bank memory model. Even addresses answer after EVEN_LATENCY
// cycles, odd ones after ODD_LATENCY, so responses come back out of order.
// Each response reserves its slot in a shared delay line, which keeps two
// responses from ever leaving in the same cycle.
`timescale 1ns/100ps
`default_nettype none

module bank_memory
(
    input  wire logic                        clk,
    input  wire logic                        reset,
    rd_req_if.sink                           req,
    output logic                             rsp_valid,
    output logic [ord_rd_pkg::IDX_BITS-1:0]  rsp_idx,
    output logic [ord_rd_pkg::DATA_BITS-1:0] rsp_data
);
    import ord_rd_pkg::*;

    // Stage that an even address enters to leave after EVEN_LATENCY cycles
    localparam int EVEN_STAGE = ODD_LATENCY - EVEN_LATENCY;
    localparam int STAGE_BITS = $clog2(ODD_LATENCY);

    logic [ODD_LATENCY-1:0] stg_valid;
    logic [IDX_BITS-1:0]    stg_idx [ODD_LATENCY];
    logic [DATA_BITS-1:0]   stg_data [ODD_LATENCY];
    logic [STAGE_BITS-1:0]  entry_stage;
    logic [DATA_BITS-1:0]   rom_word;
    logic                   accept;

    // Contents follow the multiplier rule, truncated to the word width
    assign rom_word = ROM_MULT * {{(DATA_BITS-ADDR_BITS){1'b0}}, req.addr};

    // Odd addresses use the first stage, which nothing shifts into
    assign entry_stage = req.addr[0] ? '0 : STAGE_BITS'(EVEN_STAGE);

    // An even request waits while an older response is about to fill its slot
    assign req.ready = req.addr[0] || !stg_valid[EVEN_STAGE-1];
    assign accept = req.valid && req.ready;

    always_ff @(posedge clk)
    begin
        if (reset)
            stg_valid <= '0;
        else
        begin
            stg_valid <= stg_valid << 1;
            if (accept)
                stg_valid[entry_stage] <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        for (int i = ODD_LATENCY - 1; i > 0; i--)
        begin
            stg_idx[i] <= stg_idx[i-1];
            stg_data[i] <= stg_data[i-1];
        end
        if (accept)
        begin
            stg_idx[entry_stage] <= req.idx;
            stg_data[entry_stage] <= rom_word;
        end
    end

    assign rsp_valid = stg_valid[ODD_LATENCY-1];
    assign rsp_idx = stg_idx[ODD_LATENCY-1];
    assign rsp_data = stg_data[ODD_LATENCY-1];

    // Only an odd response can be overwritten by an even one entering its stage,
    // so an odd response leaving on time with its own tag means no double write
    a_odd_latency: assert property (@(posedge clk) disable iff (reset)
        accept && req.addr[0] |-> ##ODD_LATENCY
            rsp_valid && (rsp_idx == $past(req.idx, ODD_LATENCY)));

endmodule

`default_nettype wire

// ==== design/ordered_read_top.sv ====
// Top level of the ordered read subsystem. Two clients request words, and the
// answers leave on one valid/ready output in the order the requests were granted.
// resp_client tells which client a response belongs to.
`timescale 1ns/100ps
`default_nettype none

module ordered_read_top
(
    input  wire logic                            clk,
    input  wire logic                            reset,
    input  wire logic                            req0_valid,
    output logic                                 req0_ready,
    input  wire logic [ord_rd_pkg::ADDR_BITS-1:0] req0_addr,
    input  wire logic                            req1_valid,
    output logic                                 req1_ready,
    input  wire logic [ord_rd_pkg::ADDR_BITS-1:0] req1_addr,
    output logic                                 resp_valid,
    input  wire logic                            resp_ready,
    output logic [ord_rd_pkg::DATA_BITS-1:0]      resp_data,
    output logic [ord_rd_pkg::META_BITS-1:0]      resp_client
);
    import ord_rd_pkg::*;

    rd_req_if   mem_req ();
    sb_alloc_if sb_alloc ();

    // Memory response path, always accepted by the scoreboard
    logic                 rsp_valid;
    logic [IDX_BITS-1:0]  rsp_idx;
    logic [DATA_BITS-1:0] rsp_data;

    req_arbiter arbiter_i
    (
        .clk        (clk),
        .reset      (reset),
        .req0_valid (req0_valid),
        .req0_ready (req0_ready),
        .req0_addr  (req0_addr),
        .req1_valid (req1_valid),
        .req1_ready (req1_ready),
        .req1_addr  (req1_addr),
        .mem        (mem_req),
        .alloc      (sb_alloc)
    );

    bank_memory memory_i
    (
        .clk       (clk),
        .reset     (reset),
        .req       (mem_req),
        .rsp_valid (rsp_valid),
        .rsp_idx   (rsp_idx),
        .rsp_data  (rsp_data)
    );

    // Output dequeues on the resp handshake
    rd_scoreboard_obuf sb_obuf_i
    (
        .clk        (clk),
        .reset      (reset),
        .alloc      (sb_alloc),
        .rsp_valid  (rsp_valid),
        .rsp_idx    (rsp_idx),
        .rsp_data   (rsp_data),
        .deq_en     (resp_valid && resp_ready),
        .not_empty  (resp_valid),
        .first      (resp_data),
        .first_meta (resp_client)
    );

endmodule

`default_nettype wire

// ==== tb/tb_ordered_read.sv ====
// Testbench of the ordered read subsystem. A table of rows is applied in turn;
// each row sets active clients, address pattern, request count and output stall.
// Accepted requests go into a reference queue that every response pops and checks.
`timescale 1ns/100ps
`default_nettype none

module tb_ordered_read;
    import ord_rd_pkg::*;

    localparam int MODE_EVEN = 0;
    localparam int MODE_ODD = 1;
    localparam int MODE_ALT = 2;
    localparam int MODE_RAND = 3;
    localparam int N_ROWS = 6;
    // Shortest run of refused cycles that counts as real back-pressure
    localparam int MIN_BLOCKED = 8;

    typedef struct {
        string      name;
        logic [1:0] mask;
        int         mode;
        int         count;
        int         stall;
        bit         check_alt;
    } row_t;

    logic                 clk;
    logic                 reset;
    logic                 req0_valid;
    logic                 req0_ready;
    logic [ADDR_BITS-1:0] req0_addr;
    logic                 req1_valid;
    logic                 req1_ready;
    logic [ADDR_BITS-1:0] req1_addr;
    logic                 resp_valid;
    logic                 resp_ready;
    logic [DATA_BITS-1:0] resp_data;
    logic [META_BITS-1:0] resp_client;

    row_t                 rows [N_ROWS];
    // Reference queues hold accepted requests in grant order
    logic [META_BITS-1:0] ref_client_q [$];
    logic [ADDR_BITS-1:0] ref_addr_q [$];
    logic [31:0]          rnd_state;
    int                   errors;
    int                   checks;
    int                   rows_run;
    bit                   timed_out;

    ordered_read_top ordered_read_top_i
    (
        .clk         (clk),
        .reset       (reset),
        .req0_valid  (req0_valid),
        .req0_ready  (req0_ready),
        .req0_addr   (req0_addr),
        .req1_valid  (req1_valid),
        .req1_ready  (req1_ready),
        .req1_addr   (req1_addr),
        .resp_valid  (resp_valid),
        .resp_ready  (resp_ready),
        .resp_data   (resp_data),
        .resp_client (resp_client)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Memory word at an address, the full product cut down to the word width
    function automatic logic [DATA_BITS-1:0] rom_rule(input logic [ADDR_BITS-1:0] addr);
        logic [63:0] product;
        product = 64'(addr) * 64'(ROM_MULT);
        return product[DATA_BITS-1:0];
    endfunction

    // Each client gets its own even base, so alternating mode flips parity each time
    function automatic logic [ADDR_BITS-1:0] pick_addr(input int mode, input int client,
                                                       input int seq, input logic [31:0] rnd);
        logic [ADDR_BITS-1:0] base;
        base = ADDR_BITS'(8'h10 + client * 8'h40);
        case (mode)
            MODE_EVEN: return base + ADDR_BITS'(2 * seq);
            MODE_ODD:  return base + ADDR_BITS'(2 * seq + 1);
            MODE_ALT:  return base + ADDR_BITS'(seq);
            default:   return rnd[15:8];
        endcase
    endfunction

    task automatic check_data(input string sig, input logic [DATA_BITS-1:0] got,
                              input logic [DATA_BITS-1:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("FAILED %s: got %h, expected %h", sig, got, exp);
        end
    endtask

    task automatic check_client(input string sig, input logic [META_BITS-1:0] got,
                                input logic [META_BITS-1:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("FAILED %s: got %h, expected %h", sig, got, exp);
        end
    endtask

    task automatic check_flag(input string sig, input logic got, input logic exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("FAILED %s: got %h, expected %h", sig, got, exp);
        end
    endtask

    // Applies one row; observes the last edge first, then drives the next cycle
    task automatic run_row(input int r, input row_t row);
        logic [1:0]           valid_now;
        logic [ADDR_BITS-1:0] addr_now [2];
        int                   to_send [2];
        int                   seq [2];
        logic [1:0]           hs;
        int                   cycle;
        int                   limit;
        int                   accepted;
        int                   answered;
        int                   blocked_run;
        int                   blocked_max;
        int                   err_start;
        bit                   have_last;
        logic                 last_client;
        bit                   done;
        logic [ADDR_BITS-1:0] exp_addr;
        logic [META_BITS-1:0] exp_client;

        valid_now = 2'b00;
        for (int c = 0; c < 2; c++)
        begin
            to_send[c] = row.mask[c] ? row.count : 0;
            seq[c] = 0;
            addr_now[c] = '0;
        end
        cycle = 0;
        limit = 300 + row.stall + 40 * row.count;
        accepted = 0;
        answered = 0;
        blocked_run = 0;
        blocked_max = 0;
        err_start = errors;
        have_last = 1'b0;
        last_client = 1'b0;
        done = 1'b0;
        while (!done && !timed_out)
        begin
            @(posedge clk);
            hs = {req1_valid && req1_ready, req0_valid && req0_ready};
            if (hs == 2'b11)
            begin
                errors++;
                $display("both clients were granted in the same cycle");
            end
            for (int c = 0; c < 2; c++)
            begin
                if (hs[c])
                begin
                    ref_client_q.push_back(META_BITS'(c));
                    ref_addr_q.push_back(c == 0 ? req0_addr : req1_addr);
                    accepted++;
                end
            end
            // With both clients waiting, the winner must differ from the last one
            if (row.check_alt && req0_valid && req1_valid && (hs != 2'b00) && have_last)
            begin
                checks++;
                if (hs[1] == last_client)
                begin
                    errors++;
                    $display("client %0d was granted twice in a row while both waited", hs[1]);
                end
            end
            if (hs != 2'b00)
            begin
                have_last = 1'b1;
                last_client = hs[1];
            end
            if (resp_valid && resp_ready)
            begin
                answered++;
                if (ref_addr_q.size() == 0)
                begin
                    errors++;
                    $display("a response arrived with no request outstanding");
                end
                else
                begin
                    exp_addr = ref_addr_q.pop_front();
                    exp_client = ref_client_q.pop_front();
                    check_data("resp_data", resp_data, rom_rule(exp_addr));
                    check_client("resp_client", resp_client, exp_client);
                end
            end
            // Cycles where a client waits while the output is stalled
            if ((req0_valid || req1_valid) && (hs == 2'b00) && !resp_ready)
                blocked_run++;
            else
                blocked_run = 0;
            if (blocked_run > blocked_max)
                blocked_max = blocked_run;

            for (int c = 0; c < 2; c++)
            begin
                if (hs[c])
                begin
                    to_send[c]--;
                    seq[c]++;
                    valid_now[c] = 1'b0;
                end
                if (!valid_now[c] && (to_send[c] > 0))
                begin
                    if (row.mode == MODE_RAND)
                        rnd_state = xorshift32(rnd_state);
                    // Random rows leave about one idle cycle in four
                    if ((row.mode != MODE_RAND) || (rnd_state[1:0] != 2'b00))
                    begin
                        valid_now[c] = 1'b1;
                        addr_now[c] = pick_addr(row.mode, c, seq[c], rnd_state);
                    end
                end
            end
            req0_valid <= valid_now[0];
            req0_addr <= addr_now[0];
            req1_valid <= valid_now[1];
            req1_addr <= addr_now[1];
            resp_ready <= (cycle >= row.stall);
            cycle++;
            done = (to_send[0] == 0) && (to_send[1] == 0) && (ref_addr_q.size() == 0);
            if (!done && (cycle > limit))
            begin
                errors++;
                timed_out = 1'b1;
                $display("row %0d %s: no response within timeout", r, row.name);
            end
        end
        if ((row.stall > 0) && !timed_out)
        begin
            checks++;
            if (blocked_max < MIN_BLOCKED)
            begin
                errors++;
                $display("requests were never held off while the output was stalled");
            end
        end
        rows_run++;
        $display("row %0d %s: accepted %0d, answered %0d, errors %0d",
                 r, row.name, accepted, answered, errors - err_start);
    endtask

    initial
    begin
        clk = 1'b0;
        reset = 1'b1;
        req0_valid = 1'b0;
        req0_addr = '0;
        req1_valid = 1'b0;
        req1_addr = '0;
        resp_ready = 1'b0;
        errors = 0;
        checks = 0;
        rows_run = 0;
        timed_out = 1'b0;
        rnd_state = 32'h3c83_0cbc;

        // Name, client mask, address mode, requests per client, stall cycles, alternation
        rows[0] = '{"single_per_client", 2'b11, MODE_EVEN, 1, 0, 1'b0};
        rows[1] = '{"alternating_client0", 2'b01, MODE_ALT, 12, 0, 1'b0};
        rows[2] = '{"odd_only_client1", 2'b10, MODE_ODD, 6, 0, 1'b0};
        rows[3] = '{"both_clients_busy", 2'b11, MODE_ALT, 10, 0, 1'b1};
        rows[4] = '{"output_stall", 2'b11, MODE_ALT, 24, 80, 1'b0};
        rows[5] = '{"random_mix", 2'b11, MODE_RAND, 100, 0, 1'b0};

        repeat (3) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        check_flag("resp_valid", resp_valid, 1'b0);

        for (int r = 0; (r < N_ROWS) && !timed_out; r++)
            run_row(r, rows[r]);

        if (ref_addr_q.size() != 0)
        begin
            errors++;
            $display("%0d requests never got a response", ref_addr_q.size());
        end
        $display("rows %0d, checks %0d, errors %0d", rows_run, checks, errors);
        if ((errors == 0) && !timed_out)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
design/ord_rd_pkg.sv
design/ord_rd_ifs.sv
design/rd_scoreboard.sv
design/lutram_fifo.sv
design/rd_scoreboard_obuf.sv
design/req_arbiter.sv
design/bank_memory.sv
design/ordered_read_top.sv
tb/tb_ordered_read.sv

// ==== Makefile ====
# Verilator build and run of the ordered read subsystem testbench.
# Any variable below can be overridden on the command line, e.g. make LOG=run.log

VERILATOR  ?= verilator
TOP        ?= tb_ordered_read
FILELIST   ?= build.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
JOBS       ?= 0
VFLAGS     ?= --binary --timing --assert --timescale 1ns/100ps -j $(JOBS)
LINT_FLAGS ?= --lint-only -Wall --timing --timescale 1ns/100ps
PASS_LINE  ?= ** PASS **

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

# The run passes only if the log holds the pass line on its own
run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qxF '$(PASS_LINE)' $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
